/* hw/mil1553_settings.svh */
// ==============================
// 1553 relay constants
// bus timing, field widths and
// APB register offsets
// ==============================
`ifndef MIL1553_SETTINGS_SVH
`define MIL1553_SETTINGS_SVH

// enc_clk samples per 1553 bit time
`define MIL_SAMPLES_PER_BIT 8
// sync length in bit times
`define MIL_SYNC_BITS 3
`define MIL_WORD_BITS 16
// rt, subaddress and word count fields
`define MIL_FIELD_BITS 5
`define MIL_CNT_BITS 16

// apb bus widths
`define MIL_APB_AW 8
`define MIL_APB_DW 32

// register map, counters are read only
`define MIL_REG_CTRL   8'h00
`define MIL_REG_FILTER 8'h04
`define MIL_REG_SUBST  8'h08
`define MIL_REG_WORDS  8'h0C
`define MIL_REG_SUBSTS 8'h10
`define MIL_REG_PERR   8'h14

`endif

/* hw/mil1553_pkg.sv */
// ==============================
// 1553 relay types
// word union (command / data)
// word kind from the sync
// ==============================
`include "mil1553_settings.svh"

package mil1553_pkg;

   // one bus word, read as a command or as plain data
   typedef union packed {
      // command layout, msb first on the wire
      struct packed {
         logic [`MIL_FIELD_BITS-1:0] rt_address;
         logic                       tr;
         logic [`MIL_FIELD_BITS-1:0] sub_address;
         // word count, or mode code when sub is 0/31
         logic [`MIL_FIELD_BITS-1:0] dwcnt_mcode;
      } cmd;
      logic [`MIL_WORD_BITS-1:0] data;
   } mil1553_word_u;

   // sync polarity
   // positive first -> command, negative first -> data
   typedef enum logic {
      KIND_DATA = 1'b0,
      KIND_CMD  = 1'b1
   } mil1553_kind_e;

endpackage

/* hw/mil1553_if.sv */
// ==============================
// 1553 relay interfaces
// word_if: decoded word stream
// cfg_if: filter config, events
// ==============================
`include "mil1553_settings.svh"

// decoder to filter, no stall possible
interface mil1553_word_if import mil1553_pkg::*; ();
   // one cycle pulse, other fields sampled with it
   logic          valid;
   mil1553_kind_e kind;
   mil1553_word_u word;
   // odd parity failed on this word
   logic          parity_err;

   modport src (output valid, kind, word, parity_err);
   modport dst (input  valid, kind, word, parity_err);
endinterface

// registers to filter, event pulses back
interface mil1553_cfg_if ();
   logic                       filter_en;
   logic                       tr_check;
   logic [`MIL_FIELD_BITS-1:0] flt_rt;
   logic [`MIL_FIELD_BITS-1:0] flt_sub;
   logic                       flt_tr;
   logic [`MIL_WORD_BITS-1:0]  subst_data;
   // one cycle pulses
   logic                       word_evt;
   logic                       subst_evt;

   modport regs (
      output filter_en, tr_check, flt_rt, flt_sub, flt_tr, subst_data,
      input  word_evt, subst_evt
   );
   modport filt (
      input  filter_en, tr_check, flt_rt, flt_sub, flt_tr, subst_data,
      output word_evt, subst_evt
   );
endinterface

/* hw/mil1553_decoder.sv */
// ==============================
// 1553 receive side
// line synchronizer, sync hunt,
// manchester bit decode, parity
// ==============================
`include "mil1553_settings.svh"

module mil1553_decoder import mil1553_pkg::*; (
   input  logic        enc_clk,
   input  logic        reset_slow,
   input  logic        rx_p,
   input  logic        rx_n,
   mil1553_word_if.src wout
);
   localparam int SPB       = `MIL_SAMPLES_PER_BIT;
   localparam int HALF      = SPB / 2;
   localparam int SYNC_HALF = `MIL_SYNC_BITS * SPB / 2;
   // a data run is at most one bit time, so this still separates syncs
   localparam int SYNC_MIN  = SYNC_HALF - 2;
   localparam int NBITS     = `MIL_WORD_BITS + 1;
   localparam int PW        = $clog2(SPB);
   localparam int RW        = $clog2(SYNC_HALF) + 1;
   localparam int BW        = $clog2(NBITS);

   localparam logic [1:0] ST_HUNT  = 2'd0;
   localparam logic [1:0] ST_SYNC2 = 2'd1;
   localparam logic [1:0] ST_BITS  = 2'd2;

   logic [1:0]       p_sync;
   logic [1:0]       n_sync;
   logic [1:0]       state;
   logic             run_lvl;
   logic [RW-1:0]    run_cnt;
   logic [PW-1:0]    phase;
   logic [BW-1:0]    bit_cnt;
   mil1553_kind_e    kind_q;
   logic             first_half;
   logic [NBITS-1:0] shift_q;
   logic [NBITS-1:0] shift_nxt;
   logic             line;
   logic             line_ok;
   logic             mid_first;
   logic             mid_second;
   logic             bit_good;
   logic             word_done;

   // two flop synchronizer on both lines
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         p_sync <= 2'b00;
         n_sync <= 2'b00;
      end else begin
         p_sync <= {p_sync[0], rx_p};
         n_sync <= {n_sync[0], rx_n};
      end
   end

   // line level, only valid when the pair is differential
   assign line    = p_sync[1];
   assign line_ok = p_sync[1] ^ n_sync[1];

   // half bit centres
   assign mid_first  = (state == ST_BITS) && (phase == PW'(HALF / 2));
   assign mid_second = (state == ST_BITS) && (phase == PW'(HALF + HALF / 2));
   // manchester needs a mid bit transition
   assign bit_good   = mid_second && line_ok && (line != first_half);
   assign word_done  = bit_good && (bit_cnt == BW'(NBITS - 1));
   assign shift_nxt  = {shift_q[NBITS-2:0], first_half};

   // ==============================
   // sync hunt and bit framing
   // ==============================
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         state           <= ST_HUNT;
         run_lvl         <= 1'b0;
         run_cnt         <= '0;
         phase           <= '0;
         bit_cnt         <= '0;
         kind_q          <= KIND_DATA;
         wout.valid      <= 1'b0;
         wout.parity_err <= 1'b0;
      end else begin
         wout.valid      <= word_done;
         // odd parity over 16 data bits plus parity bit
         wout.parity_err <= word_done && !(^shift_nxt);
         case (state)
            ST_HUNT: begin
               if (!line_ok) begin
                  run_cnt <= '0;
               end else if (line == run_lvl) begin
                  // saturate, long idle high is harmless
                  if (run_cnt != '1) begin
                     run_cnt <= run_cnt + 1'b1;
                  end
               end else if (run_cnt >= RW'(SYNC_MIN)) begin
                  // long run then opposite level, sync second half
                  state   <= ST_SYNC2;
                  run_cnt <= RW'(1);
                  kind_q  <= run_lvl ? KIND_CMD : KIND_DATA;
               end else begin
                  run_lvl <= line;
                  run_cnt <= RW'(1);
               end
            end
            ST_SYNC2: begin
               if (!line_ok || (line == run_lvl)) begin
                  state   <= ST_HUNT;
                  run_cnt <= '0;
               end else if (run_cnt == RW'(SYNC_HALF - 1)) begin
                  state   <= ST_BITS;
                  phase   <= '0;
                  bit_cnt <= '0;
               end else begin
                  run_cnt <= run_cnt + 1'b1;
               end
            end
            ST_BITS: begin
               phase <= (phase == PW'(SPB - 1)) ? '0 : phase + 1'b1;
               if (mid_second) begin
                  // bad bit aborts, last bit ends the word early
                  if (!bit_good || word_done) begin
                     state   <= ST_HUNT;
                     run_cnt <= '0;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: state <= ST_HUNT;
         endcase
      end
   end

   // data path, msb first
   always_ff @(posedge enc_clk) begin
      if (mid_first) begin
         first_half <= line;
      end
      if (bit_good) begin
         shift_q <= shift_nxt;
      end
      if (word_done) begin
         wout.word.data <= shift_nxt[NBITS-1:1];
         wout.kind      <= kind_q;
      end
   end

endmodule

/* hw/mil1553_msg_filter.sv */
// ==============================
// 1553 message filter
// command match, data countdown
// and data substitution
// ==============================
`include "mil1553_settings.svh"

module mil1553_msg_filter import mil1553_pkg::*; (
   input  logic          enc_clk,
   input  logic          reset_slow,
   mil1553_word_if.dst   win,
   mil1553_cfg_if.filt   cfg,
   output logic          enc_valid,
   output mil1553_kind_e enc_kind,
   output mil1553_word_u enc_word
);
   // countdown holds up to 32
   localparam int CW = `MIL_FIELD_BITS + 1;

   logic [CW-1:0] dw_left;
   logic          good;
   logic          is_cmd;
   logic          cmd_match;
   logic          do_subst;

   // bad parity words are dropped here
   assign good   = win.valid && !win.parity_err;
   assign is_cmd = (win.kind == KIND_CMD);

   // field compare, t/r only when asked for
   assign cmd_match = (win.word.cmd.rt_address == cfg.flt_rt) &&
                      (win.word.cmd.sub_address == cfg.flt_sub) &&
                      (!cfg.tr_check || (win.word.cmd.tr == cfg.flt_tr));

   assign do_subst = good && !is_cmd && cfg.filter_en && (dw_left != '0);

   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         dw_left       <= '0;
         enc_valid     <= 1'b0;
         cfg.word_evt  <= 1'b0;
         cfg.subst_evt <= 1'b0;
      end else begin
         enc_valid     <= good;
         cfg.word_evt  <= good;
         cfg.subst_evt <= do_subst;
         if (good && is_cmd) begin
            // any command restarts the count, a miss clears it
            if (cfg.filter_en && cmd_match) begin
               dw_left <= (win.word.cmd.dwcnt_mcode == '0) ?
                          CW'(1 << `MIL_FIELD_BITS) : {1'b0, win.word.cmd.dwcnt_mcode};
            end else begin
               dw_left <= '0;
            end
         end else if (good && (dw_left != '0)) begin
            dw_left <= dw_left - 1'b1;
         end
      end
   end

   // word to encoder, one cycle behind the decoder
   always_ff @(posedge enc_clk) begin
      if (win.valid) begin
         enc_kind      <= win.kind;
         enc_word.data <= do_subst ? cfg.subst_data : win.word.data;
      end
   end

endmodule

/* hw/mil1553_encoder.sv */
// ==============================
// 1553 transmit side
// manchester serializer
// sync, 16 data bits, parity
// ==============================
`include "mil1553_settings.svh"

module mil1553_encoder import mil1553_pkg::*; (
   input  logic          enc_clk,
   input  logic          reset_slow,
   input  logic          enc_valid,
   input  mil1553_kind_e enc_kind,
   input  mil1553_word_u enc_word,
   output logic          tx_p,
   output logic          tx_n,
   output logic          tx_busy
);
   localparam int SPB       = `MIL_SAMPLES_PER_BIT;
   localparam int HALF      = SPB / 2;
   localparam int SYNC_HALF = `MIL_SYNC_BITS * SPB / 2;
   localparam int NBITS     = `MIL_WORD_BITS + 1;
   // whole word in bit times, sync included
   localparam int TOTAL     = `MIL_SYNC_BITS + NBITS;
   localparam int PW        = $clog2(SPB);
   localparam int BW        = $clog2(TOTAL);

   logic [PW-1:0]    phase;
   logic [BW-1:0]    bt;
   logic [NBITS-1:0] shift_q;
   logic             sync_hi;
   logic             bit_end;
   logic             in_sync;
   logic             sync_first;
   logic             level;

   assign bit_end    = (phase == PW'(SPB - 1));
   assign in_sync    = (bt < BW'(`MIL_SYNC_BITS));
   // first 1.5 bit times of the sync
   assign sync_first = ((int'(bt) * SPB + int'(phase)) < SYNC_HALF);

   // data 1 is high then low
   always_comb begin
      if (in_sync) begin
         level = sync_first ? sync_hi : !sync_hi;
      end else begin
         level = shift_q[NBITS-1] ^ (phase >= PW'(HALF));
      end
   end

   // differential while busy, both low when idle
   assign tx_p = tx_busy & level;
   assign tx_n = tx_busy & ~level;

   // ==============================
   // bit timing
   // ==============================
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         tx_busy <= 1'b0;
         phase   <= '0;
         bt      <= '0;
      end else if (!tx_busy) begin
         // a word offered while busy is lost
         if (enc_valid) begin
            tx_busy <= 1'b1;
            phase   <= '0;
            bt      <= '0;
         end
      end else begin
         phase <= bit_end ? '0 : phase + 1'b1;
         if (bit_end) begin
            if (bt == BW'(TOTAL - 1)) begin
               tx_busy <= 1'b0;
            end else begin
               bt <= bt + 1'b1;
            end
         end
      end
   end

   // load word plus odd parity, shift after each data bit
   always_ff @(posedge enc_clk) begin
      if (enc_valid && !tx_busy) begin
         shift_q <= {enc_word.data, ~^enc_word.data};
         sync_hi <= (enc_kind == KIND_CMD);
      end else if (tx_busy && bit_end && !in_sync) begin
         shift_q <= {shift_q[NBITS-2:0], 1'b0};
      end
   end

endmodule

/* hw/mil1553_apb_regs.sv */
// ==============================
// 1553 relay APB slave
// config registers, event
// counters, read mux
// ==============================
`include "mil1553_settings.svh"

module mil1553_apb_regs (
   input  logic                   enc_clk,
   input  logic                   reset_slow,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`MIL_APB_AW-1:0] paddr,
   input  logic [`MIL_APB_DW-1:0] pwdata,
   output logic [`MIL_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   mil1553_cfg_if.regs            cfg,
   input  logic                   perr_evt
);
   localparam int NEVT = 3;

   logic                     access;
   logic                     wr_en;
   logic                     addr_hit;
   logic [NEVT-1:0]          evt;
   logic [`MIL_CNT_BITS-1:0] evt_cnt [NEVT];

   // access phase only, no wait states
   assign access  = psel & penable;
   assign wr_en   = access & pwrite;
   assign pready  = 1'b1;
   assign pslverr = access & ~addr_hit;

   // words, substitutions, parity drops
   assign evt = {perr_evt, cfg.subst_evt, cfg.word_evt};

   // ==============================
   // configuration writes
   // ==============================
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         cfg.filter_en  <= 1'b0;
         cfg.tr_check   <= 1'b0;
         cfg.flt_rt     <= '0;
         cfg.flt_sub    <= '0;
         cfg.flt_tr     <= 1'b0;
         cfg.subst_data <= '0;
      end else if (wr_en) begin
         // counter offsets fall through untouched
         case (paddr)
            `MIL_REG_CTRL: begin
               cfg.filter_en <= pwdata[0];
               cfg.tr_check  <= pwdata[1];
            end
            `MIL_REG_FILTER: begin
               cfg.flt_rt  <= pwdata[4:0];
               cfg.flt_sub <= pwdata[9:5];
               cfg.flt_tr  <= pwdata[10];
            end
            `MIL_REG_SUBST: cfg.subst_data <= pwdata[15:0];
            default: ;
         endcase
      end
   end

   // wrapping event counters
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         for (int i = 0; i < NEVT; i++) begin
            evt_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NEVT; i++) begin
            if (evt[i]) begin
               evt_cnt[i] <= evt_cnt[i] + 1'b1;
            end
         end
      end
   end

   // read mux, also flags unmapped offsets
   always_comb begin
      prdata   = '0;
      addr_hit = 1'b1;
      case (paddr)
         `MIL_REG_CTRL:   prdata[1:0] = {cfg.tr_check, cfg.filter_en};
         `MIL_REG_FILTER: prdata[10:0] = {cfg.flt_tr, cfg.flt_sub, cfg.flt_rt};
         `MIL_REG_SUBST:  prdata[15:0] = cfg.subst_data;
         `MIL_REG_WORDS:  prdata[`MIL_CNT_BITS-1:0] = evt_cnt[0];
         `MIL_REG_SUBSTS: prdata[`MIL_CNT_BITS-1:0] = evt_cnt[1];
         `MIL_REG_PERR:   prdata[`MIL_CNT_BITS-1:0] = evt_cnt[2];
         default:         addr_hit = 1'b0;
      endcase
   end

endmodule

/* hw/mil1553_relay_top.sv */
// ==============================
// 1553 relay top level
// decoder, filter, encoder and
// APB registers
// ==============================
`include "mil1553_settings.svh"

module mil1553_relay_top import mil1553_pkg::*; (
   input  logic                   enc_clk,
   input  logic                   reset_slow,
   // bus in
   input  logic                   rx_p,
   input  logic                   rx_n,
   // APB3 slave
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`MIL_APB_AW-1:0] paddr,
   input  logic [`MIL_APB_DW-1:0] pwdata,
   output logic [`MIL_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   // bus out
   output logic                   tx_p,
   output logic                   tx_n,
   output logic                   tx_busy
);
   // filter to encoder
   logic          enc_valid;
   mil1553_kind_e enc_kind;
   mil1553_word_u enc_word;

   mil1553_word_if word_bus ();
   mil1553_cfg_if  cfg_bus ();

   mil1553_decoder u_dec (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .rx_p       (rx_p),
      .rx_n       (rx_n),
      .wout       (word_bus.src)
   );

   mil1553_msg_filter u_flt (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .win        (word_bus.dst),
      .cfg        (cfg_bus.filt),
      .enc_valid  (enc_valid),
      .enc_kind   (enc_kind),
      .enc_word   (enc_word)
   );

   mil1553_encoder u_enc (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .enc_valid  (enc_valid),
      .enc_kind   (enc_kind),
      .enc_word   (enc_word),
      .tx_p       (tx_p),
      .tx_n       (tx_n),
      .tx_busy    (tx_busy)
   );

   // parity drops counted straight from the decoder
   mil1553_apb_regs u_regs (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .cfg        (cfg_bus.regs),
      .perr_evt   (word_bus.parity_err)
   );

endmodule

/* verif/mil1553_relay_checker.sv */
// ==============================
// relay protocol assertions
// bound into the relay top level
// ==============================

module mil1553_relay_checker (
   input logic enc_clk,
   input logic reset_slow,
   input logic tx_p,
   input logic tx_n,
   input logic tx_busy,
   input logic enc_valid,
   input logic pready
);
   timeunit 1ns;
   timeprecision 100ps;

   // failed assertions so far, polled by the testbench
   int assert_fails = 0;

   // differential output while sending
   a_tx_diff: assert property (@(posedge enc_clk) disable iff (reset_slow)
      tx_busy |-> (tx_n == !tx_p))
      else begin
         $error("tx_n is not the inverse of tx_p while busy");
         assert_fails++;
      end

   // bus released when idle
   a_tx_idle: assert property (@(posedge enc_clk) disable iff (reset_slow)
      !tx_busy |-> (!tx_p && !tx_n))
      else begin
         $error("tx lines not both low while idle");
         assert_fails++;
      end

   // encoder never offered a word mid transmission
   a_no_overrun: assert property (@(posedge enc_clk) disable iff (reset_slow)
      enc_valid |-> !tx_busy)
      else begin
         $error("enc_valid arrived while the encoder was busy");
         assert_fails++;
      end

   a_pready: assert property (@(posedge enc_clk) disable iff (reset_slow) pready)
      else begin
         $error("pready dropped low");
         assert_fails++;
      end

endmodule

bind mil1553_relay_top mil1553_relay_checker u_chk (
   .enc_clk    (enc_clk),
   .reset_slow (reset_slow),
   .tx_p       (tx_p),
   .tx_n       (tx_n),
   .tx_busy    (tx_busy),
   .enc_valid  (enc_valid),
   .pready     (pready)
);

/* verif/tb_mil1553_relay.sv */
// ==============================
// 1553 relay testbench
// clock, reset, APB tasks, bus
// driver, monitor and model
// ==============================
`include "mil1553_settings.svh"

module tb_mil1553_relay import mil1553_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SPB      = `MIL_SAMPLES_PER_BIT;
   localparam int SYNC_CYC = `MIL_SYNC_BITS * SPB;
   localparam int WORD_CYC = SYNC_CYC + (`MIL_WORD_BITS + 1) * SPB;
   localparam int TIMEOUT  = 3 * WORD_CYC;

   logic                   enc_clk = 1'b0;
   logic                   reset_slow;
   logic                   rx_p;
   logic                   rx_n;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`MIL_APB_AW-1:0] paddr;
   logic [`MIL_APB_DW-1:0] pwdata;
   logic [`MIL_APB_DW-1:0] prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   tx_p;
   logic                   tx_n;
   logic                   tx_busy;

   int                     seed = 48;
   string                  test_name = "none";
   logic [`MIL_APB_DW-1:0] rd;
   logic                   err;

   // model state, mirrors the register settings
   int                         left = 0;
   int                         exp_words = 0;
   int                         exp_substs = 0;
   int                         exp_perr = 0;
   logic                       filt_en = 1'b0;
   logic                       trc = 1'b0;
   logic [`MIL_FIELD_BITS-1:0] frt = '0;
   logic [`MIL_FIELD_BITS-1:0] fsub = '0;
   logic                       ftr = 1'b0;
   logic [`MIL_WORD_BITS-1:0]  subst = '0;
   mil1553_word_u              exp_w [$];
   mil1553_kind_e              exp_k [$];
   mil1553_word_u              got_w [$];
   mil1553_kind_e              got_k [$];

   // output monitor state
   int                        mon_cyc = 0;
   logic [`MIL_WORD_BITS:0]   mon_bits;
   mil1553_kind_e             mon_kind;
   mil1553_word_u             mon_word;

   always #2 enc_clk = ~enc_clk;

   mil1553_relay_top dut0 (.*);

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_word(input mil1553_word_u exp, input mil1553_word_u act);
      if (act !== exp) begin
         $display("MISMATCH %s word: expected %h actual %h", test_name, exp.data, act.data);
         stop_run();
      end
   endtask

   task automatic check_kind(input mil1553_kind_e exp, input mil1553_kind_e act);
      if (act !== exp) begin
         $display("MISMATCH %s kind: expected %s actual %s", test_name, exp.name(), act.name());
         stop_run();
      end
   endtask

   task automatic check_reg(input string what, input logic [`MIL_APB_DW-1:0] exp,
                            input logic [`MIL_APB_DW-1:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   function automatic int rnd(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // ==============================
   // APB master
   // ==============================
   task automatic apb_xfer(input logic wr, input logic [`MIL_APB_AW-1:0] addr,
                           input logic [`MIL_APB_DW-1:0] wdata,
                           output logic [`MIL_APB_DW-1:0] rdata, output logic slverr);
      int n;
      n = 0;
      @(posedge enc_clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge enc_clk);
      #1;
      penable = 1'b1;
      @(negedge enc_clk);
      while (pready !== 1'b1) begin
         @(negedge enc_clk);
         n++;
         if (n > 16) begin
            $display("APB slave never raised pready");
            stop_run();
         end
      end
      rdata  = prdata;
      slverr = pslverr;
      @(posedge enc_clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_read(input logic [`MIL_APB_AW-1:0] addr,
                           output logic [`MIL_APB_DW-1:0] data);
      logic e;
      apb_xfer(1'b0, addr, '0, data, e);
      check_reg("pslverr on read", '0, e);
   endtask

   task automatic reg_write(input logic [`MIL_APB_AW-1:0] addr,
                            input logic [`MIL_APB_DW-1:0] data);
      logic [`MIL_APB_DW-1:0] d;
      logic                   e;
      apb_xfer(1'b1, addr, data, d, e);
      check_reg("pslverr on write", '0, e);
   endtask

   // program the filter and read every register back
   task automatic configure(input logic en, input logic tc, input logic [4:0] rt,
                            input logic [4:0] sub, input logic tr, input logic [15:0] sd);
      logic [`MIL_APB_DW-1:0] d;
      filt_en = en;
      trc     = tc;
      frt     = rt;
      fsub    = sub;
      ftr     = tr;
      subst   = sd;
      reg_write(`MIL_REG_CTRL, {30'd0, tc, en});
      reg_write(`MIL_REG_FILTER, {21'd0, tr, sub, rt});
      reg_write(`MIL_REG_SUBST, {16'd0, sd});
      reg_read(`MIL_REG_CTRL, d);
      check_reg("CTRL", {30'd0, tc, en}, d);
      reg_read(`MIL_REG_FILTER, d);
      check_reg("FILTER", {21'd0, tr, sub, rt}, d);
      reg_read(`MIL_REG_SUBST, d);
      check_reg("SUBST", {16'd0, sd}, d);
   endtask

   task automatic check_counters();
      logic [`MIL_APB_DW-1:0] d;
      reg_read(`MIL_REG_WORDS, d);
      check_reg("WORDS", 32'(exp_words), d);
      reg_read(`MIL_REG_SUBSTS, d);
      check_reg("SUBSTS", 32'(exp_substs), d);
      reg_read(`MIL_REG_PERR, d);
      check_reg("PERR", 32'(exp_perr), d);
   endtask

   // ==============================
   // bus driver and model
   // ==============================
   task automatic set_level(input logic lvl);
      @(posedge enc_clk);
      #1;
      rx_p = lvl;
      rx_n = ~lvl;
   endtask

   task automatic idle_line(input int n);
      repeat (n) begin
         @(posedge enc_clk);
         #1;
         rx_p = 1'b0;
         rx_n = 1'b0;
      end
   endtask

   // sync, then 16 data bits and parity, a 1 is high then low
   task automatic drive_word(input mil1553_kind_e kind, input mil1553_word_u w,
                             input logic bad);
      logic [`MIL_WORD_BITS:0] bits;
      bits = {w.data, (~^w.data) ^ bad};
      for (int i = 0; i < SYNC_CYC; i++) begin
         set_level((kind == KIND_CMD) ^ (i >= SYNC_CYC / 2));
      end
      for (int b = `MIL_WORD_BITS; b >= 0; b--) begin
         for (int s = 0; s < SPB; s++) begin
            set_level(bits[b] ^ (s >= SPB / 2));
         end
      end
   endtask

   task automatic model_word(input mil1553_kind_e kind, input mil1553_word_u w,
                             input logic bad);
      mil1553_word_u o;
      o = w;
      if (bad) begin
         exp_perr++;
      end else begin
         exp_words++;
         if (kind == KIND_CMD) begin
            if (filt_en && (w.cmd.rt_address == frt) && (w.cmd.sub_address == fsub) &&
                (!trc || (w.cmd.tr == ftr))) begin
               left = (w.cmd.dwcnt_mcode == 0) ? 32 : int'(w.cmd.dwcnt_mcode);
            end else begin
               left = 0;
            end
         end else if (left > 0) begin
            if (filt_en) begin
               o.data = subst;
               exp_substs++;
            end
            left--;
         end
         exp_w.push_back(o);
         exp_k.push_back(kind);
      end
   endtask

   task automatic send_word(input mil1553_kind_e kind, input mil1553_word_u w,
                            input logic bad);
      int gap;
      model_word(kind, w, bad);
      drive_word(kind, w, bad);
      // short gap keeps the encoder free for the next word
      gap = 2 + rnd(4);
      if (rnd(6) == 0) begin
         gap = gap + 20 + rnd(40);
      end
      idle_line(gap);
   endtask

   // command, then 0 to 4 data words
   task automatic send_message();
      mil1553_word_u w;
      int            ndata;
      w.data = 16'($random(seed));
      if (rnd(2) == 0) begin
         w.cmd.rt_address  = frt;
         w.cmd.sub_address = fsub;
      end
      w.cmd.dwcnt_mcode = 5'(rnd(8));
      send_word(KIND_CMD, w, rnd(8) == 0);
      ndata = rnd(5);
      for (int i = 0; i < ndata; i++) begin
         w.data = 16'($random(seed));
         send_word(KIND_DATA, w, rnd(8) == 0);
      end
   endtask

   task automatic send_cmd(input logic [4:0] rt, input logic [4:0] cnt, input int ndata);
      mil1553_word_u w;
      w.data            = 16'($random(seed));
      w.cmd.rt_address  = rt;
      w.cmd.sub_address = fsub;
      w.cmd.dwcnt_mcode = cnt;
      send_word(KIND_CMD, w, 1'b0);
      for (int i = 0; i < ndata; i++) begin
         w.data = 16'($random(seed));
         send_word(KIND_DATA, w, 1'b0);
      end
   endtask

   // wait for the output to catch up, then compare in order
   task automatic flush_compare();
      int n;
      n = 0;
      while (got_w.size() < exp_w.size()) begin
         @(negedge enc_clk);
         n++;
         if (n > TIMEOUT) begin
            $display("DUT sent no further word within the timeout");
            stop_run();
         end
      end
      while (exp_w.size() > 0) begin
         check_kind(exp_k.pop_front(), got_k.pop_front());
         check_word(exp_w.pop_front(), got_w.pop_front());
      end
   endtask

   // ==============================
   // output monitor
   // ==============================
   always @(negedge enc_clk) begin
      if (tx_busy !== 1'b1) begin
         mon_cyc = 0;
      end else begin
         if (mon_cyc == 0) begin
            mon_kind = tx_p ? KIND_CMD : KIND_DATA;
         end
         // first half of each bit carries its value
         if ((mon_cyc >= SYNC_CYC) && ((mon_cyc - SYNC_CYC) % SPB == SPB / 4)) begin
            mon_bits = {mon_bits[`MIL_WORD_BITS-1:0], tx_p};
         end
         if (mon_cyc == WORD_CYC - 1) begin
            if (^mon_bits !== 1'b1) begin
               $display("output word %h has even parity", mon_bits);
               stop_run();
            end
            mon_word.data = mon_bits[`MIL_WORD_BITS:1];
            got_w.push_back(mon_word);
            got_k.push_back(mon_kind);
         end
         mon_cyc++;
      end
   end

   always @(negedge enc_clk) begin
      if (dut0.u_chk.assert_fails != 0) begin
         $display("a bound assertion on the DUT failed");
         stop_run();
      end
   end

   initial begin
      reset_slow = 1'b1;
      rx_p       = 1'b0;
      rx_n       = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      repeat (5) @(posedge enc_clk);
      #1;
      reset_slow = 1'b0;

      test_name = "reset";
      check_counters();
      reg_read(`MIL_REG_CTRL, rd);
      check_reg("CTRL", '0, rd);

      test_name = "passthrough";
      configure(1'b0, 1'b0, 5'd5, 5'd9, 1'b0, 16'hA5C3);
      repeat (6) send_message();
      flush_compare();

      test_name = "substitute";
      configure(1'b1, 1'b0, 5'd5, 5'd9, 1'b0, 16'hA5C3);
      repeat (10) send_message();
      flush_compare();

      // count field 0 means 32 words, the 33rd passes unchanged
      test_name = "count_zero";
      send_cmd(frt, 5'd0, 33);
      flush_compare();

      test_name = "mid_count";
      send_cmd(frt, 5'd5, 2);
      send_cmd(frt + 5'd1, 5'd3, 2);
      flush_compare();

      test_name = "tr_check";
      configure(1'b1, 1'b1, 5'h12, 5'h03, 1'b1, 16'h3C0F);
      repeat (10) send_message();
      flush_compare();

      test_name = "counters";
      check_counters();
      apb_xfer(1'b1, `MIL_REG_WORDS, 32'hFFFF, rd, err);
      check_reg("pslverr on read-only write", '0, err);
      check_counters();
      apb_xfer(1'b0, 8'h18, '0, rd, err);
      check_reg("pslverr on unmapped read", 32'd1, err);
      apb_xfer(1'b1, 8'h1C, 32'h1, rd, err);
      check_reg("pslverr on unmapped write", 32'd1, err);

      idle_line(WORD_CYC);
      if ((got_w.size() == 0) && (exp_w.size() == 0)) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("DUT sent words that the model did not expect");
         stop_run();
      end
   end

endmodule

/* vlog.f */
+incdir+hw
hw/mil1553_pkg.sv
hw/mil1553_if.sv
hw/mil1553_decoder.sv
hw/mil1553_msg_filter.sv
hw/mil1553_encoder.sv
hw/mil1553_apb_regs.sv
hw/mil1553_relay_top.sv
verif/mil1553_relay_checker.sv
verif/tb_mil1553_relay.sv

/* Bender.yml */
package:
  name: mil1553_relay

sources:
  - include_dirs:
      - hw
    files:
      - hw/mil1553_pkg.sv
      - hw/mil1553_if.sv
      - hw/mil1553_decoder.sv
      - hw/mil1553_msg_filter.sv
      - hw/mil1553_encoder.sv
      - hw/mil1553_apb_regs.sv
      - hw/mil1553_relay_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/mil1553_relay_checker.sv
      - verif/tb_mil1553_relay.sv
